// ==== Makefile ====
TOP := tb_mini_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f mini_core_top.f

obj_dir/V$(TOP): mini_core_top.f rtl/*.sv rtl/*.svh dv/*.sv dv/*.svh
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mini_core_top.f -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log || { echo "no pass message in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== dv/mini_core_model.svh ====
// Reference model: memory image, register file, model pc and expected retire queue
`ifndef MINI_CORE_MODEL_SVH
`define MINI_CORE_MODEL_SVH

`include "core_consts.svh"

// Mirror of what was loaded into the DUT memory
word_t   model_mem [`CORE_IMEM_WORDS];
word_t   model_regs [`CORE_NREGS];
word_t   model_pc;
retire_t exp_q [$];

// Reset state of the model core
function automatic void model_clear();
    for (int i = 0; i < `CORE_NREGS; i++) begin
        model_regs[i] = '0;
    end
    model_pc = '0;
    exp_q.delete();
endfunction

// Decode and execute the word at model_pc, queue what must retire
function automatic void model_issue();
    word_t      w;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    retire_t    r;
    w   = model_mem[model_pc[`CORE_IMEM_AW+1:2]];
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    // x0 is never written, so it always reads zero
    a   = model_regs[w[19:15]];
    b   = (opc == `CORE_OP_IMM) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
    r         = '0;
    r.valid   = 1'b1;
    r.pc      = model_pc;
    r.rd      = w[11:7];
    // Unknown group, funct3 gap, or funct7 other than base and SUB
    r.illegal = (opc != `CORE_OP_REG && opc != `CORE_OP_IMM)
        || (f3 inside {3'h1, 3'h2, 3'h3, 3'h5})
        || (opc == `CORE_OP_REG && f7 != `CORE_F7_BASE
            && !(f7 == `CORE_F7_SUB && f3 == `CORE_F3_ADD));
    case (f3)
        `CORE_F3_ADD: r.value = (opc == `CORE_OP_REG && f7 == `CORE_F7_SUB) ? a - b : a + b;
        `CORE_F3_XOR: r.value = a ^ b;
        `CORE_F3_OR:  r.value = a | b;
        `CORE_F3_AND: r.value = a & b;
        default:      r.value = '0;
    endcase
    if (!r.illegal && r.rd != 5'd0) begin
        model_regs[r.rd] = r.value;
    end
    exp_q.push_back(r);
    // Byte pc wraps with the memory
    model_pc = (model_pc + 32'd4) % (`CORE_IMEM_WORDS * 4);
endfunction

`endif

// ==== dv/tb_mini_core.sv ====
// Testbench for mini_core_top: random program load, run bursts, retire checks
`include "core_consts.svh"

module tb_mini_core;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    logic                     clk;
    logic                     rst_n;
    logic                     load_en;
    logic [`CORE_IMEM_AW-1:0] load_addr;
    word_t                    load_data;
    logic                     run;
    retire_t                  retire;

    integer seed;
    int     errors;
    int     timeouts;
    int     issued;
    int     retired;

    `include "mini_core_model.svh"

    mini_core_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .run       (run),
        .retire    (retire)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // Random word, mostly legal, registers x0..x7 only
    function automatic word_t make_word();
        logic [31:0] r;
        logic [31:0] imm;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        r   = $random(seed);
        imm = $random(seed);
        opc = r[11] ? `CORE_OP_REG : `CORE_OP_IMM;
        case (r[10:9])
            2'd0:    f3 = `CORE_F3_ADD;
            2'd1:    f3 = `CORE_F3_XOR;
            2'd2:    f3 = `CORE_F3_OR;
            default: f3 = `CORE_F3_AND;
        endcase
        f7 = (f3 == `CORE_F3_ADD && r[12]) ? `CORE_F7_SUB : `CORE_F7_BASE;
        // About three in sixteen broken on purpose
        case (r[17:14])
            4'd0: opc = 7'b0000011;
            4'd1: f3 = r[13] ? 3'h1 : 3'h5;
            4'd2: begin
                opc = `CORE_OP_REG;
                f7  = 7'h01;
            end
            default: ;
        endcase
        if (opc == `CORE_OP_IMM) begin
            return {imm[11:0], 2'b00, r[5:3], f3, 2'b00, r[2:0], opc};
        end
        return {f7, 2'b00, r[8:6], 2'b00, r[5:3], f3, 2'b00, r[2:0], opc};
    endfunction

    // Load n words from base while stopped, mirrored into the model
    task automatic load_program(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #2;
            load_en   = 1'b1;
            load_addr = `CORE_IMEM_AW'(base + i);
            load_data = make_word();
            model_mem[base + i] = load_data;
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
    endtask

    // run high for n cycles, the model issues in step
    task automatic run_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #2;
            run = 1'b1;
            model_issue();
            issued++;
        end
        @(posedge clk);
        #2;
        run = 1'b0;
    endtask

    // Until every issued instruction has retired, bounded
    task automatic wait_drain(input string phase);
        int cycles;
        cycles = 0;
        while (retired != issued && cycles < 40) begin
            @(posedge clk);
            cycles++;
        end
        if (retired != issued) begin
            timeouts++;
            $display("timeout waiting for drain in %s: %0d of %0d instructions retired",
                     phase, retired, issued);
        end
    endtask

    task automatic check_field(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // One retire against the head of the model queue
    task automatic check_retire();
        retire_t exp;
        if (exp_q.size() == 0) begin
            errors++;
            $display("retire at pc 0x%08h with no instruction outstanding", retire.pc);
        end else begin
            exp = exp_q.pop_front();
            retired++;
            check_field("retire.pc", retire.pc, exp.pc);
            check_field("retire.rd", word_t'(retire.rd), word_t'(exp.rd));
            check_field("retire.illegal", word_t'(retire.illegal), word_t'(exp.illegal));
            // Illegal words carry no defined value
            if (!exp.illegal) begin
                check_field("retire.value", retire.value, exp.value);
            end
        end
    endtask

    // Registered outputs, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && retire.valid) begin
            check_retire();
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        run       = 1'b0;
        seed      = 32'hb638_4eff;
        errors    = 0;
        timeouts  = 0;
        issued    = 0;
        retired   = 0;
        model_clear();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // First program, core stopped, nothing may retire
        load_program(0, 64);
        repeat (4) @(posedge clk);

        // Straight run, one issue per cycle
        run_cycles(64);
        wait_drain("first run");

        // Second program above the first, fetched in two bursts
        load_program(64, 64);
        run_cycles(20);
        repeat (6) @(posedge clk);
        run_cycles(44);
        wait_drain("split run");
        repeat (4) @(posedge clk);

        $display("retired %0d of %0d, errors %0d, timeouts %0d",
                 retired, issued, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_mini_core

// ==== mini_core_top.f ====
+incdir+rtl
+incdir+dv
rtl/core_pkg.sv
rtl/core_imem.sv
rtl/core_decode.sv
rtl/core_execute.sv
rtl/core_result.sv
rtl/mini_core_top.sv
dv/tb_mini_core.sv

// ==== rtl/core_consts.svh ====
// Width, depth and latency constants plus RV32I opcode and funct encodings
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath width
`define CORE_XLEN 32

// Instruction memory geometry, depth in 32-bit words
`define CORE_IMEM_WORDS 256
`define CORE_IMEM_AW 8

// Register file size
`define CORE_NREGS 32

// Fetch request to response, in cycles
`define CORE_FETCH_LAT 2

// Major opcodes of the two supported groups
`define CORE_OP_REG 7'b0110011
`define CORE_OP_IMM 7'b0010011

// funct3 values
`define CORE_F3_ADD 3'h0
`define CORE_F3_XOR 3'h4
`define CORE_F3_OR 3'h6
`define CORE_F3_AND 3'h7

// funct7 values, register-register group only
`define CORE_F7_BASE 7'h00
`define CORE_F7_SUB 7'h20

`endif

// ==== rtl/core_decode.sv ====
// PC sequencer, fetch request issue and decode register for the RV32I ALU groups
`include "core_consts.svh"

module core_decode (
    input  logic                clk,
    input  logic                rst_n,
    // Level run control, one fetch per cycle while high
    input  logic                run,
    output core_pkg::imem_req_t req,
    input  core_pkg::imem_rsp_t rsp,
    output core_pkg::dec_op_t   dec
);
    import core_pkg::*;

    // Byte address wrap at the end of instruction memory
    localparam word_t PC_MASK = word_t'(`CORE_IMEM_WORDS * 4 - 1);

    word_t   pc;
    word_t   pc_next;

    // Response word seen through both instruction views
    instr_u  instr;
    dec_op_t dec_d;

    // Request straight from run and the current pc
    assign req.valid = run;
    assign req.addr  = pc;

    assign pc_next = (pc + word_t'(4)) & PC_MASK;

    // Counter holds while stopped, resumes on next run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    assign instr = rsp.data;

    always_comb begin
        dec_d       = '0;
        dec_d.valid = rsp.valid;
        dec_d.pc    = rsp.addr;
        // rd, rs1 and funct3 share positions in both views
        dec_d.rd    = instr.r.rd;
        dec_d.rs1   = instr.r.rs1;
        // A fetch fault is passed on as illegal
        dec_d.illegal = rsp.illegal;

        // funct3 selects the operation in both groups
        case (instr.r.funct3)
            `CORE_F3_ADD: dec_d.alu_op = ALU_ADD;
            `CORE_F3_XOR: dec_d.alu_op = ALU_XOR;
            `CORE_F3_OR:  dec_d.alu_op = ALU_OR;
            `CORE_F3_AND: dec_d.alu_op = ALU_AND;
            default:      dec_d.illegal = 1'b1;
        endcase

        case (instr.r.opcode)
            `CORE_OP_REG: begin
                dec_d.rs2     = instr.r.rs2;
                dec_d.use_imm = 1'b0;
                // funct7 0x20 only valid with funct3 0, gives SUB
                if (instr.r.funct3 == `CORE_F3_ADD && instr.r.funct7 == `CORE_F7_SUB) begin
                    dec_d.alu_op = ALU_SUB;
                end else if (instr.r.funct7 != `CORE_F7_BASE) begin
                    dec_d.illegal = 1'b1;
                end
            end
            `CORE_OP_IMM: begin
                // 12-bit immediate, sign-extended to a full word
                dec_d.imm     = word_t'($signed(instr.i.imm12));
                dec_d.use_imm = 1'b1;
            end
            default: begin
                dec_d.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_d;
        end
    end

    // Every response matches a request issued FETCH_LAT cycles before
    a_rsp_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.valid |-> $past(req.valid, `CORE_FETCH_LAT)
    ) else $error("fetch response without matching request");

endmodule : core_decode

// ==== rtl/core_execute.sv ====
// Execute stage: register read with one-stage forwarding, ALU and ex register
module core_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::dec_op_t    dec,
    // Register file read ports, combinational
    output core_pkg::reg_idx_t   rs1_idx,
    output core_pkg::reg_idx_t   rs2_idx,
    input  core_pkg::word_t      rs1_val,
    input  core_pkg::word_t      rs2_val,
    output core_pkg::ex_res_t    ex
);
    import core_pkg::*;

    // Forward hits from the ex register
    logic    fwd_rs1;
    logic    fwd_rs2;

    word_t   op_a;
    word_t   op_b_reg;
    word_t   op_b;
    word_t   alu_out;

    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;

    // ex holds the previous instruction, not yet visible in the register file
    assign fwd_rs1 = ex.valid && !ex.illegal && (ex.rd != '0) && (ex.rd == dec.rs1);
    assign fwd_rs2 = ex.valid && !ex.illegal && (ex.rd != '0) && (ex.rd == dec.rs2);

    assign op_a     = fwd_rs1 ? ex.value : rs1_val;
    assign op_b_reg = fwd_rs2 ? ex.value : rs2_val;

    // Immediate replaces rs2 for the I group
    assign op_b = dec.use_imm ? dec.imm : op_b_reg;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_AND: alu_out = op_a & op_b;
            default: alu_out = '0;
        endcase
    end

    // Result register, also the forwarding source
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex <= '0;
        end else begin
            ex.valid   <= dec.valid;
            ex.pc      <= dec.pc;
            ex.rd      <= dec.rd;
            ex.value   <= alu_out;
            ex.illegal <= dec.illegal;
        end
    end

endmodule : core_execute

// ==== rtl/core_imem.sv ====
// Instruction memory stub: load write port and two-stage pipelined fetch response
`include "core_consts.svh"

module core_imem (
    input  logic                     clk,
    input  logic                     rst_n,
    // Load port, only while the core is stopped
    input  logic                     load_en,
    input  logic [`CORE_IMEM_AW-1:0] load_addr,
    input  core_pkg::word_t          load_data,
    // Fetch request and response
    input  core_pkg::imem_req_t      req,
    output core_pkg::imem_rsp_t      rsp
);
    import core_pkg::*;

    // Word array, no reset
    word_t mem [`CORE_IMEM_WORDS];

    // Word index from byte address, upper bits dropped so it wraps
    logic [`CORE_IMEM_AW-1:0] rd_idx;

    // First response stage
    imem_rsp_t rsp_q1;

    assign rd_idx = req.addr[`CORE_IMEM_AW+1:2];

    // Single-cycle load write
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // Read in the request cycle, then two register stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_q1 <= '0;
            rsp    <= '0;
        end else begin
            rsp_q1.valid   <= req.valid;
            rsp_q1.addr    <= req.addr;
            rsp_q1.data    <= mem[rd_idx];
            // Stub never faults
            rsp_q1.illegal <= 1'b0;

            rsp <= rsp_q1;
        end
    end

    // Loading races a fetch of the same array
    a_no_load_during_fetch: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_en && req.valid)
    ) else $error("imem load while fetch active");

    // Decoder only issues word-aligned pcs
    a_req_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid |-> (req.addr[1:0] == 2'b00)
    ) else $error("imem misaligned fetch 0x%08h", req.addr);

endmodule : core_imem

// ==== rtl/core_pkg.sv ====
// Shared core types: words, instruction views and union, ALU ops, stage structs
`include "core_consts.svh"

package core_pkg;

    // Data or byte address word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // Register-register view, R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_r_t;

    // Register-immediate view, I-type layout
    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // One fetched word, decoded through either view
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Fetch request, always accepted
    typedef struct packed {
        logic  valid;
        word_t addr;
    } imem_req_t;

    // Fetch response, address echoed back
    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
        logic  illegal;
    } imem_rsp_t;

    // Decode stage output
    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        logic     use_imm;
        logic     illegal;
    } dec_op_t;

    // Execute stage output, also the forwarding source
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     illegal;
    } ex_res_t;

    // Retired instruction
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     illegal;
    } retire_t;

endpackage : core_pkg

// ==== rtl/core_result.sv ====
// Result stage: register file with write-back, two read ports and retire register
`include "core_consts.svh"

module core_result (
    input  logic                 clk,
    input  logic                 rst_n,
    input  core_pkg::ex_res_t    ex,
    // Read ports for execute
    input  core_pkg::reg_idx_t   rs1_idx,
    input  core_pkg::reg_idx_t   rs2_idx,
    output core_pkg::word_t      rs1_val,
    output core_pkg::word_t      rs2_val,
    output core_pkg::retire_t    retire
);
    import core_pkg::*;

    word_t regs [`CORE_NREGS];

    logic  wr_en;

    // Illegal ops and x0 targets write nothing
    assign wr_en = ex.valid && !ex.illegal && (ex.rd != '0);

    // Write at the end of the ex cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex.rd] <= ex.value;
        end
    end

    // x0 hardwired to zero on read
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // Retire one cycle after ex, unchanged
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire <= '0;
        end else begin
            retire.valid   <= ex.valid;
            retire.pc      <= ex.pc;
            retire.rd      <= ex.rd;
            retire.value   <= ex.value;
            retire.illegal <= ex.illegal;
        end
    end

    // x0 storage stays at its reset value through all write-backs
    a_x0_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        $stable(regs[0])
    ) else $error("register x0 changed to 0x%08h", regs[0]);

endmodule : core_result

// ==== rtl/mini_core_top.sv ====
// Top level: instruction memory stub, decode, execute and result stages
`include "core_consts.svh"

module mini_core_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Program load, only while run is low
    input  logic                     load_en,
    input  logic [`CORE_IMEM_AW-1:0] load_addr,
    input  core_pkg::word_t          load_data,
    // Fetch enable, level
    input  logic                     run,
    output core_pkg::retire_t        retire
);
    import core_pkg::*;

    // Fetch path
    imem_req_t req;
    imem_rsp_t rsp;

    // Stage outputs
    dec_op_t   dec;
    ex_res_t   ex;

    // Register read path
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     rs1_val;
    word_t     rs2_val;

    core_imem u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .req       (req),
        .rsp       (rsp)
    );

    core_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .req   (req),
        .rsp   (rsp),
        .dec   (dec)
    );

    core_execute u_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .ex      (ex)
    );

    core_result u_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex      (ex),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .retire  (retire)
    );

endmodule : mini_core_top
